// ==== filelist.f ====
ising_cfg_pkg.sv
ising_map_pkg.sv
ising_weight_mem.sv
ising_host_port.sv
ising_sweep_ctrl.sv
ising_field_calc.sv
ising_spin_update.sv
ising_core_top.sv
ising_tb.sv

// ==== ising_tb.sv ====
// Ising core testbench
// random loads checked against a reference sweep model by concurrent assertions

`timescale 1ns/100ps

module ising_tb;
    import ising_cfg_pkg::*;
    import ising_map_pkg::*;

    localparam int TOTAL_SWEEPS = 1 + 3 + 0 + 3 + 4 + 2;  // sum over all runs
    localparam int NUM_RUNS     = 6;
    localparam int LOAD_CYC     = 24;                     // host writes per run, rounded up
    localparam int WD_CYCLES    = TOTAL_SWEEPS * (NUM_SPIN + 6) + NUM_RUNS * LOAD_CYC + 200;

    logic                   clk_i;
    logic                   arst_n_i;
    logic                   host_wr_i;
    logic [HOST_ADDR_W-1:0] host_addr_i;
    logic [HOST_DATA_W-1:0] host_wdata_i;
    logic                   busy_o;
    logic                   done_o;
    logic [NUM_SPIN-1:0]    spins_o;

    // reference model copies
    logic [J_ROW_W-1:0]  m_j [NUM_SPIN];
    logic [BIT_H-1:0]    m_h [NUM_SPIN];
    logic [NUM_SPIN-1:0] m_mask;
    logic [NUM_SPIN-1:0] m_spins;

    logic [NUM_SPIN-1:0] exp_spins;   // spins expected at done_o
    logic [NUM_SPIN-1:0] init_spins;  // spins at run start
    logic [NUM_SPIN-1:0] snap_spins;  // snapshot after the first sweep
    logic [J_ROW_W-1:0]  bad_row;     // J row written while busy
    logic                exp_busy;    // run has at least one sweep
    logic                host_touched;
    int                  err_count;
    int                  done_count;
    int                  exp_done_count;
    int                  seed;

    ising_core_top dut (
        .clk_i, .arst_n_i, .host_wr_i, .host_addr_i, .host_wdata_i,
        .busy_o, .done_o, .spins_o
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;  // 4 ns period
    end

    //////////////////////////////
    // reference model
    //////////////////////////////
    function automatic logic [NUM_SPIN-1:0] model_sweep(input logic [NUM_SPIN-1:0] s);
        logic [NUM_SPIN-1:0] nxt;
        int                  field;
        int                  coup;
        nxt = s;
        for (int i = 0; i < NUM_SPIN; i++) begin
            field = int'($signed(m_h[i]));
            for (int j = 0; j < NUM_SPIN; j++) begin
                coup = int'($signed(m_j[i][j*BIT_J +: BIT_J]));
                if (j != i) field += s[j] ? coup : -coup;  // s_j is +1 or -1
            end
            // zero field and masked spins keep the old value
            if (!m_mask[i] && field > 0) nxt[i] = 1'b1;
            if (!m_mask[i] && field < 0) nxt[i] = 1'b0;
        end
        return nxt;
    endfunction

    //////////////////////////////
    // host side tasks
    //////////////////////////////
    task automatic host_write(input logic [HOST_ADDR_W-1:0] addr,
                              input logic [HOST_DATA_W-1:0] data);
        @(posedge clk_i);
        host_wr_i    <= 1'b1;
        host_addr_i  <= addr;
        host_wdata_i <= data;
        host_touched = 1'b1;
    endtask

    task automatic host_release();
        @(posedge clk_i);
        host_wr_i <= 1'b0;
    endtask

    task automatic load_row(input int i, input logic [J_ROW_W-1:0] row,
                            input logic [BIT_H-1:0] bias);
        host_write(ADDR_J_BASE + HOST_ADDR_W'(i), row);
        host_write(ADDR_H_BASE + HOST_ADDR_W'(i), HOST_DATA_W'(bias));
        m_j[i] = row;
        m_h[i] = bias;
    endtask

    task automatic load_state(input logic [NUM_SPIN-1:0] s, input logic [NUM_SPIN-1:0] mask);
        host_write(ADDR_SPIN_INIT, HOST_DATA_W'(s));
        host_write(ADDR_FLIP_MASK, HOST_DATA_W'(mask));
        m_spins = s;
        m_mask  = mask;
    endtask

    task automatic load_random(input logic [NUM_SPIN-1:0] mask);
        logic [31:0] r_j;
        logic [31:0] r_h;
        logic [31:0] r_s;
        for (int i = 0; i < NUM_SPIN; i++) begin
            r_j = $random(seed);
            r_h = $random(seed);
            load_row(i, r_j, r_h[BIT_H-1:0]);
        end
        r_s = $random(seed);
        load_state(r_s[NUM_SPIN-1:0], mask);
    endtask

    task automatic start_run(input int n);
        init_spins = m_spins;
        exp_spins  = m_spins;
        for (int k = 0; k < n; k++) exp_spins = model_sweep(exp_spins);
        exp_busy = (n != 0);
        exp_done_count++;
        host_write(ADDR_SWEEPS, HOST_DATA_W'(n));
        host_write(ADDR_START, '0);
        host_release();
    endtask

    task automatic wait_done();
        do @(negedge clk_i); while (!done_o);  // watchdog bounds this
        @(posedge clk_i);  // end of the done_o cycle
        m_spins = exp_spins;
    endtask

    task automatic run_sweeps(input int n);
        start_run(n);
        wait_done();
    endtask

    always @(negedge clk_i) begin
        if (arst_n_i && done_o) done_count++;
    end

    //////////////////////////////
    // assertions
    //////////////////////////////
    a_reset_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !host_touched |-> !busy_o && !done_o && spins_o == '0)
        else begin
            err_count++;
            $display("Mismatch after reset: busy_o %h done_o %h spins_o %h",
                     $sampled(busy_o), $sampled(done_o), $sampled(spins_o));
        end

    a_spins: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        done_o |-> spins_o == exp_spins)
        else begin
            err_count++;
            $display("Mismatch spins_o: got %h expected %h",
                     $sampled(spins_o), $sampled(exp_spins));
        end

    a_mask: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        done_o |-> ((spins_o ^ init_spins) & m_mask) == '0)
        else begin
            err_count++;
            $display("Mismatch masked spins_o: got %h expected %h",
                     $sampled(spins_o & m_mask), $sampled(init_spins & m_mask));
        end

    a_done_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        done_o |-> !busy_o && (!exp_busy || $past(busy_o)))
        else begin
            err_count++;
            $display("done_o came while busy_o was high or without busy_o before it");
        end

    a_busy_fall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $fell(busy_o) |-> done_o)
        else begin
            err_count++;
            $display("busy_o dropped without a done_o strobe");
        end

    a_zero_run: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !exp_busy |-> !busy_o)
        else begin
            err_count++;
            $display("busy_o went high on a run with zero sweeps");
        end

    a_done_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        done_o |=> !done_o)
        else begin
            err_count++;
            $display("done_o stayed high for more than one cycle");
        end

    //////////////////////////////
    // stimulus
    //////////////////////////////
    initial begin
        seed           = 70723;
        arst_n_i       = 1'b0;
        host_wr_i      = 1'b0;
        host_addr_i    = '0;
        host_wdata_i   = '0;
        exp_spins      = '0;
        init_spins     = '0;
        snap_spins     = '0;
        bad_row        = '0;
        m_mask         = '0;
        exp_busy       = 1'b0;
        host_touched   = 1'b0;
        err_count      = 0;
        done_count     = 0;
        exp_done_count = 0;
        repeat (10) @(posedge clk_i);
        arst_n_i <= 1'b1;
        repeat (5) @(posedge clk_i);  // idle after reset

        load_random('0);  // one sweep
        run_sweeps(1);

        load_random('0);  // several sweeps, then zero sweeps
        run_sweeps(3);
        run_sweeps(0);

        // masked spins get rows and biases that push them the other way
        load_random(8'h5A);
        for (int i = 0; i < NUM_SPIN; i++) begin
            if (m_mask[i]) load_row(i, '0, m_spins[i] ? 4'h8 : 4'h7);
        end
        run_sweeps(3);

        for (int i = 0; i < NUM_SPIN; i++) load_row(i, '0, '0);  // zero field
        load_state(m_spins ^ 8'hC3, '0);
        run_sweeps(4);

        // a J write and a second start during the run must be dropped
        load_random('0);
        start_run(2);
        // row 0 that would drive spin 0 against its expected value in sweep 2
        snap_spins = model_sweep(init_spins);
        for (int j = 0; j < NUM_SPIN; j++) begin
            bad_row[j*BIT_J +: BIT_J] = (snap_spins[j] ^ exp_spins[0]) ? 4'h7 : 4'h9;
        end
        do @(negedge clk_i); while (!busy_o);
        host_write(ADDR_J_BASE, bad_row);
        host_write(ADDR_START, '0);
        host_release();
        wait_done();
        repeat (NUM_SPIN + 20) @(posedge clk_i);  // room for a stray second run

        a_done_cnt: assert (done_count == exp_done_count)
            else begin
                err_count++;
                $display("Mismatch done_o count: got %h expected %h", done_count, exp_done_count);
            end

        $display("checks done, %0d errors", err_count);
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk_i);
        $display("Timeout: run still going after %0d cycles, %0d errors so far",
                 WD_CYCLES, err_count);
        $display("Errors found");
        $finish;
    end

endmodule

// ==== ising_core_top.sv ====
// Ising core top level
// host port, sweep controller, J and h memories, field and update stages

`timescale 1ns/100ps

module ising_core_top (
    input  logic                                 clk_i,
    input  logic                                 arst_n_i,

    input  logic                                 host_wr_i,
    input  logic [ising_map_pkg::HOST_ADDR_W-1:0] host_addr_i,
    input  logic [ising_map_pkg::HOST_DATA_W-1:0] host_wdata_i,

    output logic                                 busy_o,
    output logic                                 done_o,
    output logic [ising_cfg_pkg::NUM_SPIN-1:0]   spins_o
);
    import ising_cfg_pkg::*;

    // host port outputs
    logic                  j_we, h_we, spin_init_we, start;
    logic [SPIN_IDX_W-1:0] j_waddr, h_waddr;
    j_row_t                j_wdata;
    h_bias_t               h_wdata;
    logic [NUM_SPIN-1:0]   spin_init, flip_mask;
    logic [SWEEP_W-1:0]    sweeps;

    // pipeline
    logic                  rd_en, mem_valid, fld_valid, sweep_commit;
    logic [SPIN_IDX_W-1:0] rd_idx, mem_idx, fld_idx;
    j_row_t                j_row;
    h_bias_t               h_bias;
    field_t                field;

    ising_host_port u_host_port (
        .clk_i, .arst_n_i, .host_wr_i, .host_addr_i, .host_wdata_i,
        .busy_i        (busy_o      ),
        .j_we_o        (j_we        ), .j_waddr_o (j_waddr), .j_wdata_o (j_wdata),
        .h_we_o        (h_we        ), .h_waddr_o (h_waddr), .h_wdata_o (h_wdata),
        .spin_init_we_o(spin_init_we), .spin_init_o(spin_init),
        .flip_mask_o   (flip_mask   ), .start_o   (start  ), .sweeps_o  (sweeps )
    );

    ising_sweep_ctrl u_sweep_ctrl (
        .clk_i, .arst_n_i,
        .start_i(start), .sweeps_i(sweeps), .sweep_commit_i(sweep_commit),
        .rd_en_o(rd_en), .rd_idx_o(rd_idx), .busy_o, .done_o
    );

    //////////////////////////////
    // weight memories
    //////////////////////////////
    ising_weight_mem #(.word_t(j_row_t)) u_j_mem (
        .clk_i, .arst_n_i, .we_i(j_we), .waddr_i(j_waddr), .wdata_i(j_wdata),
        .re_i(rd_en), .raddr_i(rd_idx), .rdata_o(j_row)
    );

    ising_weight_mem #(.word_t(h_bias_t)) u_h_mem (
        .clk_i, .arst_n_i, .we_i(h_we), .waddr_i(h_waddr), .wdata_i(h_wdata),
        .re_i(rd_en), .raddr_i(rd_idx), .rdata_o(h_bias)
    );

    // tag follows the memory read latency
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) mem_valid <= 1'b0;
        else           mem_valid <= rd_en;
    end

    always_ff @(posedge clk_i) mem_idx <= rd_idx;

    //////////////////////////////
    // datapath
    //////////////////////////////
    ising_field_calc u_field_calc (
        .clk_i, .arst_n_i, .valid_i(mem_valid), .idx_i(mem_idx),
        .j_row_i(j_row), .h_bias_i(h_bias), .spins_i(spins_o),
        .valid_o(fld_valid), .idx_o(fld_idx), .field_o(field)
    );

    ising_spin_update u_spin_update (
        .clk_i, .arst_n_i, .valid_i(fld_valid), .idx_i(fld_idx), .field_i(field),
        .flip_mask_i(flip_mask), .spin_init_we_i(spin_init_we), .spin_init_i(spin_init),
        .spins_o, .sweep_commit_o(sweep_commit)
    );

endmodule

// ==== ising_spin_update.sv ====
// Ising spin update stage
// decides each new spin into a shadow register and commits it at the sweep end

`timescale 1ns/100ps

module ising_spin_update (
    input  logic                                 clk_i,
    input  logic                                 arst_n_i,

    // from the field stage
    input  logic                                 valid_i,
    input  logic [ising_cfg_pkg::SPIN_IDX_W-1:0] idx_i,
    input  ising_cfg_pkg::field_t                field_i,

    // host side
    input  logic [ising_cfg_pkg::NUM_SPIN-1:0]   flip_mask_i,
    input  logic                                 spin_init_we_i,
    input  logic [ising_cfg_pkg::NUM_SPIN-1:0]   spin_init_i,

    output logic [ising_cfg_pkg::NUM_SPIN-1:0]   spins_o,
    output logic                                 sweep_commit_o
);
    import ising_cfg_pkg::*;

    logic [NUM_SPIN-1:0] shadow_q;     // spins decided so far this sweep
    logic [NUM_SPIN-1:0] spins_q;      // snapshot seen by the field stage
    logic [NUM_SPIN-1:0] shadow_next;
    logic                new_spin;

    //////////////////////////////
    // decision rule
    //////////////////////////////
    always_comb begin
        if (flip_mask_i[idx_i]) begin
            new_spin = spins_q[idx_i];  // frozen
        end else if (field_i > 0) begin
            new_spin = 1'b1;
        end else if (field_i < 0) begin
            new_spin = 1'b0;
        end else begin
            new_spin = spins_q[idx_i];  // zero field keeps the old value
        end
    end

    always_comb begin
        shadow_next        = shadow_q;
        shadow_next[idx_i] = new_spin;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            shadow_q       <= '0;
            spins_q        <= '0;
            sweep_commit_o <= 1'b0;
        end else begin
            sweep_commit_o <= 1'b0;
            if (spin_init_we_i) begin
                shadow_q <= spin_init_i;
                spins_q  <= spin_init_i;
            end else if (valid_i) begin
                shadow_q <= shadow_next;
                if (idx_i == LAST_IDX) begin  // last spin of the sweep
                    spins_q        <= shadow_next;
                    sweep_commit_o <= 1'b1;
                end
            end
        end
    end

    assign spins_o = spins_q;

endmodule

// ==== ising_field_calc.sv ====
// Ising local field stage
// field of spin i = h_i + sum over j != i of J_ij * s_j, registered with its tag

`timescale 1ns/100ps

module ising_field_calc (
    input  logic                                 clk_i,
    input  logic                                 arst_n_i,

    // from the weight memories
    input  logic                                 valid_i,
    input  logic [ising_cfg_pkg::SPIN_IDX_W-1:0] idx_i,
    input  ising_cfg_pkg::j_row_t                j_row_i,
    input  ising_cfg_pkg::h_bias_t               h_bias_i,

    // committed snapshot of the previous sweep
    input  logic [ising_cfg_pkg::NUM_SPIN-1:0]   spins_i,

    // to the update stage
    output logic                                 valid_o,
    output logic [ising_cfg_pkg::SPIN_IDX_W-1:0] idx_o,
    output ising_cfg_pkg::field_t                field_o
);
    import ising_cfg_pkg::*;

    field_t field_sum;

    //////////////////////////////
    // accumulation
    //////////////////////////////
    always_comb begin
        field_t coup;

        coup      = '0;
        field_sum = field_t'(h_bias_i);  // bias, sign extended
        for (int j = 0; j < NUM_SPIN; j++) begin
            coup = field_t'($signed(j_row_i[j*BIT_J +: BIT_J]));
            // diagonal term is not part of the field
            if (j != idx_i) begin
                // bit 1 is +1, bit 0 is -1
                if (spins_i[j]) begin
                    field_sum = field_sum + coup;
                end else begin
                    field_sum = field_sum - coup;
                end
            end
        end
    end

    //////////////////////////////
    // output register
    //////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        idx_o   <= idx_i;     // tag travels with the field
        field_o <= field_sum;
    end

endmodule

// ==== ising_sweep_ctrl.sv ====
// Ising sweep controller
// walks the spin indices once per sweep and counts sweeps down to done

`timescale 1ns/100ps

module ising_sweep_ctrl (
    input  logic                                 clk_i,
    input  logic                                 arst_n_i,

    input  logic                                 start_i,
    input  logic [ising_cfg_pkg::SWEEP_W-1:0]    sweeps_i,
    input  logic                                 sweep_commit_i,

    output logic                                 rd_en_o,
    output logic [ising_cfg_pkg::SPIN_IDX_W-1:0] rd_idx_o,
    output logic                                 busy_o,
    output logic                                 done_o
);
    import ising_cfg_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,   // one read per cycle
        ST_WAIT,    // drain until the sweep is committed
        ST_FINISH
    } state_t;

    state_t              state_q;
    logic [SPIN_IDX_W-1:0] idx_q;
    logic [SWEEP_W-1:0]  sweep_left_q;  // sweeps still to run, current one included

    //////////////////////////////
    // FSM
    //////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q      <= ST_IDLE;
            idx_q        <= '0;
            sweep_left_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        idx_q        <= '0;
                        sweep_left_q <= sweeps_i;
                        // zero sweeps finish straight away
                        state_q      <= (sweeps_i == '0) ? ST_FINISH : ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    if (idx_q == LAST_IDX) begin
                        idx_q   <= '0;
                        state_q <= ST_WAIT;
                    end else begin
                        idx_q <= idx_q + 1'b1;
                    end
                end
                ST_WAIT: begin
                    if (sweep_commit_i) begin
                        if (sweep_left_q == SWEEP_W'(1)) begin
                            state_q <= ST_FINISH;
                        end else begin
                            sweep_left_q <= sweep_left_q - 1'b1;
                            state_q      <= ST_ISSUE;
                        end
                    end
                end
                default: state_q <= ST_IDLE;  // finish lasts one cycle
            endcase
        end
    end

    assign rd_en_o  = (state_q == ST_ISSUE);
    assign rd_idx_o = idx_q;
    assign busy_o   = (state_q == ST_ISSUE) || (state_q == ST_WAIT);
    assign done_o   = (state_q == ST_FINISH);  // busy already low here

endmodule

// ==== ising_host_port.sv ====
// Ising host port
// decodes host writes into memory writes, spin init, mask, sweep count and start

`timescale 1ns/100ps

module ising_host_port (
    input  logic                                 clk_i,
    input  logic                                 arst_n_i,

    input  logic                                 host_wr_i,
    input  logic [ising_map_pkg::HOST_ADDR_W-1:0] host_addr_i,
    input  logic [ising_map_pkg::HOST_DATA_W-1:0] host_wdata_i,
    input  logic                                 busy_i,

    output logic                                 j_we_o,
    output logic [ising_cfg_pkg::SPIN_IDX_W-1:0] j_waddr_o,
    output ising_cfg_pkg::j_row_t                j_wdata_o,
    output logic                                 h_we_o,
    output logic [ising_cfg_pkg::SPIN_IDX_W-1:0] h_waddr_o,
    output ising_cfg_pkg::h_bias_t               h_wdata_o,
    output logic                                 spin_init_we_o,
    output logic [ising_cfg_pkg::NUM_SPIN-1:0]   spin_init_o,
    output logic [ising_cfg_pkg::NUM_SPIN-1:0]   flip_mask_o,
    output logic                                 start_o,
    output logic [ising_cfg_pkg::SWEEP_W-1:0]    sweeps_o
);
    import ising_cfg_pkg::*;
    import ising_map_pkg::*;

    logic                   wr_ok;
    logic [HOST_ADDR_W-1:0] j_off;
    logic [HOST_ADDR_W-1:0] h_off;

    assign wr_ok = host_wr_i && !busy_i;  // nothing gets through during a run

    // offsets wrap below the base, so one compare covers the window
    assign j_off = host_addr_i - ADDR_J_BASE;
    assign h_off = host_addr_i - ADDR_H_BASE;

    // strobes and config registers
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            j_we_o         <= 1'b0;
            h_we_o         <= 1'b0;
            spin_init_we_o <= 1'b0;
            start_o        <= 1'b0;
            flip_mask_o    <= '0;
            sweeps_o       <= '0;
        end else begin
            j_we_o         <= wr_ok && (j_off < NUM_SPIN);
            h_we_o         <= wr_ok && (h_off < NUM_SPIN);
            spin_init_we_o <= wr_ok && (host_addr_i == ADDR_SPIN_INIT);
            start_o        <= wr_ok && (host_addr_i == ADDR_START);
            if (wr_ok && (host_addr_i == ADDR_FLIP_MASK)) begin
                flip_mask_o <= host_wdata_i[NUM_SPIN-1:0];
            end
            if (wr_ok && (host_addr_i == ADDR_SWEEPS)) begin
                sweeps_o <= host_wdata_i[SWEEP_W-1:0];
            end
        end
    end

    // write payload, qualified by the strobes above
    always_ff @(posedge clk_i) begin
        j_waddr_o   <= j_off[SPIN_IDX_W-1:0];
        j_wdata_o   <= host_wdata_i[J_ROW_W-1:0];
        h_waddr_o   <= h_off[SPIN_IDX_W-1:0];
        h_wdata_o   <= host_wdata_i[BIT_H-1:0];
        spin_init_o <= host_wdata_i[NUM_SPIN-1:0];
    end

endmodule

// ==== ising_weight_mem.sv ====
// Ising weight memory
// host-written array of NUM_SPIN words with a registered read port

`timescale 1ns/100ps

module ising_weight_mem #(
    parameter type word_t = logic
) (
    input  logic                               clk_i,
    input  logic                               arst_n_i,

    // host side write
    input  logic                               we_i,
    input  logic [ising_cfg_pkg::SPIN_IDX_W-1:0] waddr_i,
    input  word_t                              wdata_i,

    // pipeline side read
    input  logic                               re_i,
    input  logic [ising_cfg_pkg::SPIN_IDX_W-1:0] raddr_i,
    output word_t                              rdata_o
);
    import ising_cfg_pkg::*;

    word_t mem_q [NUM_SPIN];  // one word per spin

    // write port
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // read data shows up one cycle after re_i and holds until the next read
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdata_o <= '0;
        end else if (re_i) begin
            rdata_o <= mem_q[raddr_i];
        end
    end

endmodule

// ==== ising_map_pkg.sv ====
// Ising core host map
// address and data widths of the host write port and the register offsets

package ising_map_pkg;

    localparam int HOST_ADDR_W = 5;
    localparam int HOST_DATA_W = 32;

    //////////////////////////////
    // memory windows
    //////////////////////////////

    // J row i sits at ADDR_J_BASE + i, one full row per word
    localparam logic [HOST_ADDR_W-1:0] ADDR_J_BASE = 5'h00;

    // bias i sits at ADDR_H_BASE + i, low BIT_H bits used
    localparam logic [HOST_ADDR_W-1:0] ADDR_H_BASE = 5'h08;

    //////////////////////////////
    // single registers
    //////////////////////////////
    localparam logic [HOST_ADDR_W-1:0] ADDR_SPIN_INIT = 5'h10;  // low NUM_SPIN bits
    localparam logic [HOST_ADDR_W-1:0] ADDR_FLIP_MASK = 5'h11;  // 1 = spin frozen
    localparam logic [HOST_ADDR_W-1:0] ADDR_SWEEPS    = 5'h12;  // low SWEEP_W bits

    // any write here kicks off a run, data is don't care
    localparam logic [HOST_ADDR_W-1:0] ADDR_START     = 5'h13;

endpackage

// ==== ising_cfg_pkg.sv ====
// Ising core configuration
// spin array size and datapath widths shared by the pipeline stages

package ising_cfg_pkg;

    //////////////////////////////
    // spin array
    //////////////////////////////
    localparam int NUM_SPIN   = 8;
    localparam int SPIN_IDX_W = 3;  // enough to index NUM_SPIN

    // index of the last spin in a sweep
    localparam logic [SPIN_IDX_W-1:0] LAST_IDX = SPIN_IDX_W'(NUM_SPIN - 1);

    //////////////////////////////
    // arithmetic widths
    //////////////////////////////
    localparam int BIT_J   = 4;                 // signed coupling
    localparam int BIT_H   = 4;                 // signed bias
    localparam int J_ROW_W = NUM_SPIN * BIT_J;  // one packed J row
    localparam int FIELD_W = 8;                 // holds +-(NUM_SPIN-1)*8 plus bias
    localparam int SWEEP_W = 8;

    //////////////////////////////
    // payload types
    //////////////////////////////

    // nibble j of a row is J_ij, read as signed
    typedef logic [J_ROW_W-1:0] j_row_t;

    typedef logic signed [BIT_H-1:0] h_bias_t;

    typedef logic signed [FIELD_W-1:0] field_t;

endpackage
